// File: project.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_load_path.sv
hdl/lsu_store_path.sv
hdl/lsu_resp_merge.sv
hdl/lsu_sram.sv
hdl/lsu_top.sv
tests/tb_clkgen.sv
tests/tb_lsu_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_lsu_top -f project.f -o sim_lsu \
  && ./obj_dir/sim_lsu 2>&1 | tee sim.log

grep -q "Simulation completed successfully" sim.log \
  && echo "RESULT: PASS" \
  || { echo "RESULT: FAIL"; exit 1; }

// File: tests/tb_lsu_top.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module tb_lsu_top
  import lsu_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 200;

  logic                   clk;
  logic                   arst_n_i;
  logic                   req_valid_i;
  lsu_req_t               req_i;
  logic                   done_o;
  logic [`LSU_DATA_W-1:0] rdata_o;
  logic [31:0]            lcg_state;
  logic [31:0]            model [`LSU_MEM_WORDS];

  tb_clkgen i_clkgen (.clk_o(clk));

  lsu_top i_dut (
    .clk(clk), .arst_n_i(arst_n_i), .req_valid_i(req_valid_i), .req_i(req_i),
    .done_o(done_o), .rdata_o(rdata_o)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected load value from a model word
  function automatic logic [31:0] expected_load(input lsu_op_e op, input logic [31:0] word,
                                               input logic [1:0] off);
    logic [31:0] shifted;
    shifted = word >> {off, 3'b000};
    case (op)
      LSU_LB:  return {{24{shifted[7]}}, shifted[7:0]};
      LSU_LBU: return {24'h0, shifted[7:0]};
      LSU_LH:  return {{16{shifted[15]}}, shifted[15:0]};
      LSU_LHU: return {16'h0, shifted[15:0]};
      default: return word;
    endcase
  endfunction

  // new model word after a store
  function automatic logic [31:0] merge_store(input lsu_op_e op, input logic [31:0] old,
                                             input logic [1:0] off, input logic [31:0] data);
    logic [31:0] mask;
    case (op)
      LSU_SB:  mask = 32'h0000_00ff;
      LSU_SH:  mask = 32'h0000_ffff;
      default: mask = 32'hffff_ffff;
    endcase
    mask = mask << {off, 3'b000};
    return (old & ~mask) | ((data << {off, 3'b000}) & mask);
  endfunction

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s, expected %08h, got %08h", $time, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value check failed");
    end
  endtask

  // runs one request, entered and left 1 ns after a rising edge
  task automatic run_request(input lsu_op_e op, input logic [3:0] idx, input logic [1:0] off,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int   waited;
    logic is_store;
    is_store = (op == LSU_SB) || (op == LSU_SH) || (op == LSU_SW);
    req_i.ren   = !is_store;
    req_i.wen   = is_store;
    req_i.op    = op;
    req_i.addr  = {26'h0, idx, off};
    req_i.wdata = wdata;
    req_valid_i = 1'b1;
    waited = 0;
    @(posedge clk);
    #1;
    while (!done_o) begin
      if (waited == TIMEOUT_CYCLES) begin
        $display("ERROR: the load/store unit never completed a request within %0d cycles",
                 TIMEOUT_CYCLES);
        $display("Simulation failed");
        $fatal(1, "request timeout");
      end
      waited++;
      @(posedge clk);
      #1;
    end
    rdata = rdata_o;
    if (is_store) begin
      check_value(32'h0, rdata_o, "rdata on store completion");
    end
    req_valid_i = 1'b0;
    req_i       = '0;
    // done is a single-cycle pulse
    @(posedge clk);
    #1;
    check_value(32'h0, {31'h0, done_o}, "second done pulse");
  endtask

  task automatic do_store(input lsu_op_e op, input logic [3:0] idx, input logic [1:0] off,
                          input logic [31:0] data);
    logic [31:0] unused;
    run_request(op, idx, off, data, unused);
    model[idx] = merge_store(op, model[idx], off, data);
  endtask

  task automatic load_and_check(input lsu_op_e op, input logic [3:0] idx,
                                input logic [1:0] off);
    logic [31:0] got;
    run_request(op, idx, off, next_rand(), got);
    check_value(expected_load(op, model[idx], off), got,
                $sformatf("%s word %0d offset %0d", op.name(), idx, off));
  endtask

  initial begin
    logic [31:0] r;
    logic [3:0]  idx;
    lcg_state   = 32'hd9d3;
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (16) @(posedge clk);
    #1;
    arst_n_i = 1'b1;
    @(posedge clk);
    #1;
    check_value(32'h0, {31'h0, done_o}, "done after reset");

    // fill every word, then read all back
    for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
      do_store(LSU_SW, 4'(i), 2'd0, next_rand());
    end
    for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
      load_and_check(LSU_LW, 4'(i), 2'd0);
    end

    // random word traffic
    for (int n = 0; n < 300; n++) begin
      r   = next_rand();
      idx = r[23:20];
      if (r[31]) begin
        do_store(LSU_SW, idx, 2'd0, next_rand());
      end else begin
        load_and_check(LSU_LW, idx, 2'd0);
      end
    end

    // byte lanes
    for (int n = 0; n < 8; n++) begin
      for (int off = 0; off < 4; off++) begin
        idx = 4'(next_rand() >> 28);
        do_store(LSU_SB, idx, 2'(off), next_rand());
        load_and_check(LSU_LB, idx, 2'(off));
        load_and_check(LSU_LBU, idx, 2'(off));
        load_and_check(LSU_LW, idx, 2'd0);
      end
    end

    // halfword lanes at offsets 0 and 2
    for (int n = 0; n < 8; n++) begin
      for (int off = 0; off < 4; off += 2) begin
        idx = 4'(next_rand() >> 28);
        do_store(LSU_SH, idx, 2'(off), next_rand());
        load_and_check(LSU_LH, idx, 2'(off));
        load_and_check(LSU_LHU, idx, 2'(off));
        load_and_check(LSU_LW, idx, 2'd0);
      end
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: tests/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
  output logic clk_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #50;
      clk_o = ~clk_o;
    end
  end

endmodule

// File: hdl/lsu_top.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   req_valid_i,
  input  lsu_req_t               req_i,
  output logic                   done_o,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  axi_ar_t ar;
  axi_r_t  r;
  axi_aw_t aw;
  axi_w_t  w;
  axi_b_t  b;
  logic    ar_valid;
  logic    ar_ready;
  logic    r_valid;
  logic    r_ready;
  logic    aw_valid;
  logic    aw_ready;
  logic    w_valid;
  logic    w_ready;
  logic    b_valid;
  logic    b_ready;
  logic    ld_done;
  logic    st_done;
  logic [`LSU_DATA_W-1:0] ld_data;

  lsu_load_path u_load (
    .clk(clk), .arst_n_i(arst_n_i), .req_valid_i(req_valid_i), .req_i(req_i),
    .ar_o(ar), .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
    .r_i(r), .r_valid_i(r_valid), .r_ready_o(r_ready),
    .ld_done_o(ld_done), .ld_data_o(ld_data)
  );

  lsu_store_path u_store (
    .clk(clk), .arst_n_i(arst_n_i), .req_valid_i(req_valid_i), .req_i(req_i),
    .aw_o(aw), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
    .w_o(w), .w_valid_o(w_valid), .w_ready_i(w_ready),
    .b_i(b), .b_valid_i(b_valid), .b_ready_o(b_ready),
    .st_done_o(st_done)
  );

  lsu_resp_merge u_merge (
    .clk(clk), .arst_n_i(arst_n_i), .ld_done_i(ld_done), .st_done_i(st_done),
    .ld_data_i(ld_data), .done_o(done_o), .rdata_o(rdata_o)
  );

  lsu_sram u_sram (
    .clk(clk), .arst_n_i(arst_n_i),
    .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
    .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready),
    .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
    .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
    .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready)
  );

endmodule

// File: hdl/lsu_sram.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_sram
  import lsu_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n_i,
  input  axi_ar_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  output axi_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i,
  input  axi_aw_t aw_i,
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  input  axi_w_t  w_i,
  input  logic    w_valid_i,
  output logic    w_ready_o,
  output axi_b_t  b_o,
  output logic    b_valid_o,
  input  logic    b_ready_i
);

  lsu_word_u              mem [`LSU_MEM_WORDS];
  logic [`LSU_LFSR_W-1:0] lfsr_q;
  logic [`LSU_DATA_W-1:0] rdata_q;
  logic                   r_valid_q;
  logic                   b_valid_q;
  logic                   aw_got_q;
  logic                   w_got_q;
  logic [`LSU_MEM_IDX_W-1:0] aw_idx_q;
  axi_w_t                 w_q;
  logic [`LSU_MEM_IDX_W-1:0] rd_idx;
  logic [`LSU_MEM_IDX_W-1:0] wr_idx;
  axi_w_t                 wr_beat;
  logic                   ar_hs;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   wr_fire;

  // spread the stall bits across the register
  assign ar_ready_o = !r_valid_q && lfsr_q[3];
  assign aw_ready_o = !aw_got_q && !b_valid_q && lfsr_q[9];
  assign w_ready_o  = !w_got_q && !b_valid_q && lfsr_q[15];

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;

  assign rd_idx  = ar_i.araddr[`LSU_MEM_IDX_W+1:2];
  assign wr_idx  = aw_got_q ? aw_idx_q : aw_i.awaddr[`LSU_MEM_IDX_W+1:2];
  assign wr_beat = w_got_q ? w_q : w_i;
  assign wr_fire = (aw_got_q || aw_hs) && (w_got_q || w_hs);

  assign r_o.rdata = rdata_q;
  assign r_o.rresp = AXI_RESP_OKAY;
  assign r_valid_o = r_valid_q;
  assign b_o.bresp = AXI_RESP_OKAY;
  assign b_valid_o = b_valid_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q    <= `LSU_LFSR_SEED;
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
    end else begin
      lfsr_q <= {lfsr_q[`LSU_LFSR_W-2:0], ^(lfsr_q & `LSU_LFSR_TAPS)};
      if (ar_hs) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
      if (wr_fire) begin
        b_valid_q <= 1'b1;
        aw_got_q  <= 1'b0;
        w_got_q   <= 1'b0;
      end else begin
        if (b_ready_i) begin
          b_valid_q <= 1'b0;
        end
        aw_got_q <= aw_got_q || aw_hs;
        w_got_q  <= w_got_q || w_hs;
      end
    end
  end

  // storage and captured beats
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata_q <= mem[rd_idx].word;
    end
    if (aw_hs) begin
      aw_idx_q <= aw_i.awaddr[`LSU_MEM_IDX_W+1:2];
    end
    if (w_hs) begin
      w_q <= w_i;
    end
    if (wr_fire) begin
      for (int i = 0; i < `LSU_STRB_W; i++) begin
        if (wr_beat.wstrb[i]) begin
          mem[wr_idx].bytes[i] <= wr_beat.wdata[i*8 +: 8];
        end
      end
    end
  end

endmodule

// File: hdl/lsu_resp_merge.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_resp_merge
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   ld_done_i,
  input  logic                   st_done_i,
  input  logic [`LSU_DATA_W-1:0] ld_data_i,
  output logic                   done_o,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  logic [`LSU_DATA_W-1:0] rdata_q;
  logic                   done_q;

  assign done_o  = done_q;
  assign rdata_o = rdata_q;

  // only one path finishes per request
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q  <= 1'b0;
      rdata_q <= '0;
    end else begin
      done_q <= ld_done_i || st_done_i;
      if (ld_done_i) begin
        rdata_q <= ld_data_i;
      end else begin
        // stores and idle cycles read back as zero
        rdata_q <= '0;
      end
    end
  end

endmodule

// File: hdl/lsu_store_path.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_store_path
  import lsu_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     req_valid_i,
  input  lsu_req_t req_i,
  output axi_aw_t  aw_o,
  output logic     aw_valid_o,
  input  logic     aw_ready_i,
  output axi_w_t   w_o,
  output logic     w_valid_o,
  input  logic     w_ready_i,
  input  axi_b_t   b_i,
  input  logic     b_valid_i,
  output logic     b_ready_o,
  output logic     st_done_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ADDR,
    S_RESP,
    S_CMPL,
    S_HOLD
  } st_state_e;

  st_state_e              state_q;
  st_state_e              state_d;
  logic                   aw_got_q;
  logic                   w_got_q;
  logic                   start;
  logic                   issue;
  logic                   aw_ok;
  logic                   w_ok;
  logic                   b_hs;
  logic [`LSU_STRB_W-1:0] strb_base;
  lsu_word_u              wlane;

  assign start = (state_q == S_IDLE) && req_valid_i && req_i.wen;
  assign issue = start || (state_q == S_ADDR);

  // aw and w leave together and each drops once its own handshake is done
  assign aw_valid_o = issue && !aw_got_q;
  assign w_valid_o  = issue && !w_got_q;
  assign aw_ok      = aw_got_q || (aw_valid_o && aw_ready_i);
  assign w_ok       = w_got_q || (w_valid_o && w_ready_i);
  assign b_ready_o  = (state_q == S_RESP);
  assign b_hs       = b_valid_i && b_ready_o && (b_i.bresp == AXI_RESP_OKAY);
  assign st_done_o  = (state_q == S_CMPL);

  assign aw_o.awaddr = {req_i.addr[`LSU_ADDR_W-1:2], 2'b00};
  assign w_o.wdata   = wlane.word;
  assign w_o.wstrb   = strb_base << req_i.addr[1:0];

  always_comb begin
    wlane.word = '0;
    case (req_i.op)
      LSU_SB: begin
        strb_base                     = 4'b0001;
        wlane.bytes[req_i.addr[1:0]]  = req_i.wdata[7:0];
      end
      LSU_SH: begin
        strb_base                         = 4'b0011;
        wlane.bytes[{req_i.addr[1], 1'b0}] = req_i.wdata[7:0];
        wlane.bytes[{req_i.addr[1], 1'b1}] = req_i.wdata[15:8];
      end
      default: begin
        strb_base  = 4'b1111;
        wlane.word = req_i.wdata;
      end
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE, S_ADDR: begin
        if (issue) begin
          state_d = (aw_ok && w_ok) ? S_RESP : S_ADDR;
        end
      end
      S_RESP: begin
        if (b_hs) begin
          state_d = S_CMPL;
        end
      end
      S_CMPL:  state_d = S_HOLD;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= S_IDLE;
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // remember a lone handshake until the other one lands
      if (issue && !(aw_ok && w_ok)) begin
        aw_got_q <= aw_ok;
        w_got_q  <= w_ok;
      end else begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/lsu_load_path.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_load_path
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   req_valid_i,
  input  lsu_req_t               req_i,
  output axi_ar_t                ar_o,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  input  axi_r_t                 r_i,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  output logic                   ld_done_o,
  output logic [`LSU_DATA_W-1:0] ld_data_o
);

  // hold covers the cycle where the merge block shows done
  typedef enum logic [2:0] {
    S_IDLE,
    S_ADDR,
    S_RESP,
    S_CMPL,
    S_HOLD
  } ld_state_e;

  ld_state_e   state_q;
  ld_state_e   state_d;
  lsu_word_u   rword_q;
  logic        start;
  logic        ar_hs;
  logic        r_hs;
  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  // address goes out in the same cycle the request shows up
  assign start       = (state_q == S_IDLE) && req_valid_i && req_i.ren;
  assign ar_valid_o  = start || (state_q == S_ADDR);
  assign ar_o.araddr = {req_i.addr[`LSU_ADDR_W-1:2], 2'b00};
  assign r_ready_o   = (state_q == S_RESP);
  assign ar_hs       = ar_valid_o && ar_ready_i;
  assign r_hs        = r_valid_i && r_ready_o;
  assign ld_done_o   = (state_q == S_CMPL);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (start) begin
          state_d = ar_hs ? S_RESP : S_ADDR;
        end
      end
      S_ADDR: begin
        if (ar_hs) begin
          state_d = S_RESP;
        end
      end
      S_RESP: begin
        if (r_hs) begin
          state_d = S_CMPL;
        end
      end
      S_CMPL:  state_d = S_HOLD;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (r_hs) begin
      rword_q.word <= r_i.rdata;
    end
  end

  // lane pick from the captured word
  always_comb begin
    lane_b = rword_q.bytes[req_i.addr[1:0]];
    lane_h = {rword_q.bytes[{req_i.addr[1], 1'b1}], rword_q.bytes[{req_i.addr[1], 1'b0}]};
    case (req_i.op)
      LSU_LB:  ld_data_o = {{24{lane_b[7]}}, lane_b};
      LSU_LBU: ld_data_o = {24'b0, lane_b};
      LSU_LH:  ld_data_o = {{16{lane_h[15]}}, lane_h};
      LSU_LHU: ld_data_o = {16'b0, lane_h};
      default: ld_data_o = rword_q.word;
    endcase
  end

endmodule

// File: hdl/lsu_pkg.sv
`include "lsu_defs.svh"

package lsu_pkg;

  // encoded access op from decode
  typedef enum logic [2:0] {
    LSU_LB  = 3'd0,
    LSU_LBU = 3'd1,
    LSU_LH  = 3'd2,
    LSU_LHU = 3'd3,
    LSU_LW  = 3'd4,
    LSU_SB  = 3'd5,
    LSU_SH  = 3'd6,
    LSU_SW  = 3'd7
  } lsu_op_e;

  typedef struct packed {
    logic                   ren;
    logic                   wen;
    lsu_op_e                op;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] wdata;
  } lsu_req_t;

  // one bus word seen whole or as byte lanes
  typedef union packed {
    logic [`LSU_DATA_W-1:0]          word;
    logic [`LSU_STRB_W-1:0][7:0]     bytes;
  } lsu_word_u;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] araddr;
  } axi_ar_t;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
  } axi_r_t;

  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] awaddr;
  } axi_aw_t;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] wdata;
    logic [`LSU_STRB_W-1:0] wstrb;
  } axi_w_t;

  typedef struct packed {
    logic [1:0] bresp;
  } axi_b_t;

endpackage

// File: hdl/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32
`define LSU_STRB_W 4

// on-chip memory of 16 words of 32 bits
`define LSU_MEM_WORDS 16
`define LSU_MEM_IDX_W 4

// stall generator with polynomial x^20 + x^17 + 1
`define LSU_LFSR_W 20
`define LSU_LFSR_TAPS 20'h90000
`define LSU_LFSR_SEED 20'h5a3c1

`endif
